/* rtl/axi_bus_pkg.sv */
// AXI3 channel widths, field types and payload structs shared by the slave and its testbench
package axi_bus_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int ID_W    = 2;
    localparam int NUM_IDS = 4;       // one tracker pair per ID
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    localparam int LEN_W   = 4;       // AXI3 burst length field
    localparam int RESP_W  = 2;

    // ------------------------------------------------------------------------
    // field types
    // ------------------------------------------------------------------------
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [ADDR_W-1:0] addr_t;     // byte address
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [LEN_W-1:0]  len_t;      // beats minus one
    typedef logic [RESP_W-1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;   // only response this slave returns

    // ------------------------------------------------------------------------
    // channel payloads
    // ------------------------------------------------------------------------

    // AW and AR share one layout
    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } addr_req_t;

    typedef struct packed {
        id_t   id;     // WID
        data_t data;
        strb_t strb;
        logic  last;
    } w_beat_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_beat_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_beat_t;

endpackage

/* rtl/mem_slave_pkg.sv */
// tracker states, word index and memory write request shared inside the AXI memory slave
package mem_slave_pkg;

    // modules keep only the low bits of this word index
    typedef logic [15:0] word_idx_t;

    // per-ID write tracker
    typedef enum logic [1:0] {
        WR_IDLE,     // waiting for AW
        WR_DATA,     // taking W beats
        WR_RESP      // waiting for B to go out
    } wr_state_e;

    // per-ID read tracker
    typedef enum logic {
        RD_IDLE,
        RD_ACTIVE    // beats still to issue
    } rd_state_e;

    // one strobed word write
    typedef struct packed {
        word_idx_t            idx;
        axi_bus_pkg::data_t   data;
        axi_bus_pkg::strb_t   strb;
    } mem_wr_t;

endpackage

/* rtl/word_ram.sv */
// word memory with one byte-strobed write port and one registered read port
module word_ram #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                        ACLK,
    input  logic                        we,
    input  mem_slave_pkg::mem_wr_t      wr,
    input  logic                        rd_en,
    input  mem_slave_pkg::word_idx_t    rd_idx,
    output axi_bus_pkg::data_t          rd_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    axi_bus_pkg::data_t mem [MEM_WORDS];

    // write lanes only where strobed
    always_ff @(posedge ACLK)
    begin
        if (we)
        begin
            for (int lane = 0; lane < axi_bus_pkg::STRB_W; lane++)
                if (wr.strb[lane])
                    mem[wr.idx[IDX_W-1:0]][lane*8 +: 8] <= wr.data[lane*8 +: 8];
        end
    end

    // output holds between reads
    always_ff @(posedge ACLK)
    begin
        if (rd_en)
            rd_data <= mem[rd_idx[IDX_W-1:0]];
    end

endmodule

/* rtl/rr_id_arbiter.sv */
// round-robin pick of the next pending ID after the last one granted; one instance per R and B
module rr_id_arbiter (
    input  logic                               ACLK,
    input  logic                               ARESETn,
    input  logic [axi_bus_pkg::NUM_IDS-1:0]    pending,
    input  logic                               advance,
    output logic                               grant_valid,
    output axi_bus_pkg::id_t                   grant_id
);

    axi_bus_pkg::id_t last_id;

    // search starts one past the last grant and wraps back round to it
    always_comb
    begin
        axi_bus_pkg::id_t cand;
        grant_valid = 1'b0;
        grant_id    = last_id;
        for (int k = 1; k <= axi_bus_pkg::NUM_IDS; k++)
        begin
            cand = last_id + axi_bus_pkg::id_t'(k);   // wraps in ID_W bits
            if (!grant_valid && pending[cand])
            begin
                grant_valid = 1'b1;
                grant_id    = cand;
            end
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            last_id <= axi_bus_pkg::id_t'(axi_bus_pkg::NUM_IDS - 1);   // ID 0 first
        else if (advance)
            last_id <= grant_id;
    end

endmodule

/* rtl/write_tracker.sv */
// per-ID write state machines; accepts AW and W, writes strobed words and drives the B register
module write_tracker #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                               ACLK,
    input  logic                               ARESETn,
    input  logic                               aw_valid,
    input  axi_bus_pkg::addr_req_t             aw,
    output logic                               aw_ready,
    input  logic                               w_valid,
    input  axi_bus_pkg::w_beat_t               w,
    output logic                               w_ready,
    output logic                               b_valid,
    output axi_bus_pkg::b_beat_t               b,
    input  logic                               b_ready,
    input  logic                               b_grant_valid,
    input  axi_bus_pkg::id_t                   b_grant_id,
    output logic [axi_bus_pkg::NUM_IDS-1:0]    resp_pending,
    output logic                               mem_we,
    output mem_slave_pkg::mem_wr_t             mem_wr
);

    localparam mem_slave_pkg::word_idx_t WORD_MASK = mem_slave_pkg::word_idx_t'(MEM_WORDS - 1);

    mem_slave_pkg::wr_state_e   wr_state [axi_bus_pkg::NUM_IDS];
    mem_slave_pkg::word_idx_t   wr_start [axi_bus_pkg::NUM_IDS];
    axi_bus_pkg::len_t          wr_cnt   [axi_bus_pkg::NUM_IDS];   // beats taken so far
    axi_bus_pkg::id_t           b_id_q;

    logic aw_xfer;
    logic w_xfer;
    logic b_xfer;
    logic b_load;

    assign aw_ready = (wr_state[aw.id] == mem_slave_pkg::WR_IDLE);
    assign w_ready  = (wr_state[w.id] == mem_slave_pkg::WR_DATA);
    assign aw_xfer  = aw_valid && aw_ready;
    assign w_xfer   = w_valid && w_ready;
    assign b_xfer   = b_valid && b_ready;
    assign b_load   = b_grant_valid && (!b_valid || b_ready);

    // every accepted beat goes to the memory on the same edge
    assign mem_we      = w_xfer;
    assign mem_wr.idx  = (wr_start[w.id] + mem_slave_pkg::word_idx_t'(wr_cnt[w.id])) & WORD_MASK;
    assign mem_wr.data = w.data;
    assign mem_wr.strb = w.strb;

    // an ID sitting in the B register no longer asks for a slot
    always_comb
    begin
        for (int i = 0; i < axi_bus_pkg::NUM_IDS; i++)
            resp_pending[i] = (wr_state[i] == mem_slave_pkg::WR_RESP) &&
                              !(b_valid && b_id_q == axi_bus_pkg::id_t'(i));
    end

    // ------------------------------------------------------------------------
    // per-ID state machines
    // ------------------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            for (int i = 0; i < axi_bus_pkg::NUM_IDS; i++)
            begin
                wr_state[i] <= mem_slave_pkg::WR_IDLE;
                wr_cnt[i]   <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < axi_bus_pkg::NUM_IDS; i++)
            begin
                case (wr_state[i])
                    mem_slave_pkg::WR_IDLE:
                        if (aw_xfer && aw.id == axi_bus_pkg::id_t'(i))
                        begin
                            wr_cnt[i]   <= '0;
                            wr_state[i] <= mem_slave_pkg::WR_DATA;
                        end
                    mem_slave_pkg::WR_DATA:
                        if (w_xfer && w.id == axi_bus_pkg::id_t'(i))
                        begin
                            wr_cnt[i] <= wr_cnt[i] + 1'b1;
                            if (w.last)
                                wr_state[i] <= mem_slave_pkg::WR_RESP;
                        end
                    mem_slave_pkg::WR_RESP:
                        if (b_xfer && b_id_q == axi_bus_pkg::id_t'(i))
                            wr_state[i] <= mem_slave_pkg::WR_IDLE;   // response gone
                    default: wr_state[i] <= mem_slave_pkg::WR_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (aw_xfer)
            wr_start[aw.id] <= aw.addr[17:2] & WORD_MASK;   // word aligned
    end

    // ------------------------------------------------------------------------
    // B output register
    // ------------------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            b_valid <= 1'b0;
        else if (b_load)
            b_valid <= 1'b1;
        else if (b_ready)
            b_valid <= 1'b0;
    end

    always_ff @(posedge ACLK)
    begin
        if (b_load)
            b_id_q <= b_grant_id;
    end

    assign b = axi_bus_pkg::b_beat_t'{id: b_id_q, resp: axi_bus_pkg::RESP_OKAY};

endmodule

/* rtl/read_tracker.sv */
// per-ID read state machines; accepts AR, issues beats to the memory and drives R control
module read_tracker #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                               ACLK,
    input  logic                               ARESETn,
    input  logic                               ar_valid,
    input  axi_bus_pkg::addr_req_t             ar,
    output logic                               ar_ready,
    input  logic                               r_ready,
    input  logic                               r_grant_valid,
    input  axi_bus_pkg::id_t                   r_grant_id,
    output logic                               r_valid,
    output axi_bus_pkg::id_t                   r_id,
    output logic                               r_last,
    output logic [axi_bus_pkg::NUM_IDS-1:0]    rd_pending,
    output logic                               rd_en,
    output mem_slave_pkg::word_idx_t           rd_idx
);

    localparam mem_slave_pkg::word_idx_t WORD_MASK = mem_slave_pkg::word_idx_t'(MEM_WORDS - 1);

    mem_slave_pkg::rd_state_e   rd_state [axi_bus_pkg::NUM_IDS];
    mem_slave_pkg::word_idx_t   rd_start [axi_bus_pkg::NUM_IDS];
    axi_bus_pkg::len_t          rd_len   [axi_bus_pkg::NUM_IDS];
    axi_bus_pkg::len_t          rd_sent  [axi_bus_pkg::NUM_IDS];   // beats issued

    logic ar_xfer;
    logic issue;
    logic beat_last;

    assign ar_ready = (rd_state[ar.id] == mem_slave_pkg::RD_IDLE);
    assign ar_xfer  = ar_valid && ar_ready;

    // R register free or emptying on this edge
    assign issue     = r_grant_valid && (!r_valid || r_ready);
    assign beat_last = (rd_sent[r_grant_id] == rd_len[r_grant_id]);

    assign rd_en  = issue;
    assign rd_idx = (rd_start[r_grant_id] +
                     mem_slave_pkg::word_idx_t'(rd_sent[r_grant_id])) & WORD_MASK;

    always_comb
    begin
        for (int i = 0; i < axi_bus_pkg::NUM_IDS; i++)
            rd_pending[i] = (rd_state[i] == mem_slave_pkg::RD_ACTIVE);
    end

    // ------------------------------------------------------------------------
    // per-ID state machines
    // ------------------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            for (int i = 0; i < axi_bus_pkg::NUM_IDS; i++)
            begin
                rd_state[i] <= mem_slave_pkg::RD_IDLE;
                rd_sent[i]  <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < axi_bus_pkg::NUM_IDS; i++)
            begin
                case (rd_state[i])
                    mem_slave_pkg::RD_IDLE:
                        if (ar_xfer && ar.id == axi_bus_pkg::id_t'(i))
                        begin
                            rd_sent[i]  <= '0;
                            rd_state[i] <= mem_slave_pkg::RD_ACTIVE;
                        end
                    mem_slave_pkg::RD_ACTIVE:
                        if (issue && r_grant_id == axi_bus_pkg::id_t'(i))
                        begin
                            rd_sent[i] <= rd_sent[i] + 1'b1;
                            if (beat_last)
                                rd_state[i] <= mem_slave_pkg::RD_IDLE;   // burst done
                        end
                    default: rd_state[i] <= mem_slave_pkg::RD_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (ar_xfer)
        begin
            rd_start[ar.id] <= ar.addr[17:2] & WORD_MASK;
            rd_len[ar.id]   <= ar.len;
        end
    end

    // ------------------------------------------------------------------------
    // R control register
    // ------------------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            r_valid <= 1'b0;
        else if (issue)
            r_valid <= 1'b1;
        else if (r_ready)
            r_valid <= 1'b0;
    end

    // data lands in the memory output register on the same edge
    always_ff @(posedge ACLK)
    begin
        if (issue)
        begin
            r_id   <= r_grant_id;
            r_last <= beat_last;
        end
    end

endmodule

/* rtl/axi_mem_slave.sv */
// AXI3 memory slave top level; connects the per-ID trackers, the two arbiters and the word memory
module axi_mem_slave #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                   ACLK,
    input  logic                   ARESETn,

    // write address
    input  logic                   aw_valid,
    input  axi_bus_pkg::addr_req_t aw,
    output logic                   aw_ready,

    // write data
    input  logic                   w_valid,
    input  axi_bus_pkg::w_beat_t   w,
    output logic                   w_ready,

    // write response
    output logic                   b_valid,
    output axi_bus_pkg::b_beat_t   b,
    input  logic                   b_ready,

    // read address
    input  logic                   ar_valid,
    input  axi_bus_pkg::addr_req_t ar,
    output logic                   ar_ready,

    // read data
    output logic                   r_valid,
    output axi_bus_pkg::r_beat_t   r,
    input  logic                   r_ready
);

    // ------------------------------------------------------------------------
    // internal wires
    // ------------------------------------------------------------------------
    logic                               mem_we;
    mem_slave_pkg::mem_wr_t             mem_wr;
    logic                               rd_en;
    mem_slave_pkg::word_idx_t           rd_idx;
    axi_bus_pkg::data_t                 rd_data;

    logic [axi_bus_pkg::NUM_IDS-1:0]    resp_pending;
    logic [axi_bus_pkg::NUM_IDS-1:0]    rd_pending;
    logic                               b_grant_valid;
    axi_bus_pkg::id_t                   b_grant_id;
    logic                               r_grant_valid;
    axi_bus_pkg::id_t                   r_grant_id;

    axi_bus_pkg::id_t                   r_id;
    logic                               r_last;
    logic                               b_advance;
    logic                               r_advance;

    // arbiters move on when their output register takes a new beat
    assign b_advance = b_grant_valid && (!b_valid || b_ready);
    assign r_advance = r_grant_valid && (!r_valid || r_ready);

    // read data comes straight from the memory output register
    assign r = axi_bus_pkg::r_beat_t'{id: r_id, data: rd_data,
                                      resp: axi_bus_pkg::RESP_OKAY, last: r_last};

    write_tracker #(.MEM_WORDS(MEM_WORDS)) u_write_tracker (
        .ACLK, .ARESETn,
        .aw_valid, .aw, .aw_ready,
        .w_valid, .w, .w_ready,
        .b_valid, .b, .b_ready,
        .b_grant_valid, .b_grant_id,
        .resp_pending, .mem_we, .mem_wr
    );

    read_tracker #(.MEM_WORDS(MEM_WORDS)) u_read_tracker (
        .ACLK, .ARESETn,
        .ar_valid, .ar, .ar_ready,
        .r_ready, .r_grant_valid, .r_grant_id,
        .r_valid, .r_id, .r_last,
        .rd_pending, .rd_en, .rd_idx
    );

    rr_id_arbiter u_b_arb (
        .ACLK, .ARESETn,
        .pending     (resp_pending),
        .advance     (b_advance),
        .grant_valid (b_grant_valid),
        .grant_id    (b_grant_id)
    );

    rr_id_arbiter u_r_arb (
        .ACLK, .ARESETn,
        .pending     (rd_pending),
        .advance     (r_advance),
        .grant_valid (r_grant_valid),
        .grant_id    (r_grant_id)
    );

    word_ram #(.MEM_WORDS(MEM_WORDS)) u_word_ram (
        .ACLK,
        .we (mem_we), .wr (mem_wr),
        .rd_en, .rd_idx, .rd_data
    );

endmodule

/* sim/tb_checks.svh */
// compare tasks and pass/fail counters that the top module of the AXI memory slave testbench includes
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int chk_cnt = 0;
int err_cnt = 0;
int pass_tests = 0;
int fail_tests = 0;
int test_err_base = 0;

task automatic check_data(string name, axi_bus_pkg::data_t exp, axi_bus_pkg::data_t act);
    chk_cnt++;
    if (act !== exp)
    begin
        err_cnt++;
        $display("ERROR %s: data expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_id(string name, axi_bus_pkg::id_t exp, axi_bus_pkg::id_t act);
    chk_cnt++;
    if (act !== exp)
    begin
        err_cnt++;
        $display("ERROR %s: id expected %0d actual %0d", name, exp, act);
    end
endtask

task automatic check_resp(string name, axi_bus_pkg::resp_t exp, axi_bus_pkg::resp_t act);
    chk_cnt++;
    if (act !== exp)
    begin
        err_cnt++;
        $display("ERROR %s: resp expected %b actual %b", name, exp, act);
    end
endtask

task automatic check_last(string name, logic exp, logic act);
    chk_cnt++;
    if (act !== exp)
    begin
        err_cnt++;
        $display("ERROR %s: last expected %b actual %b", name, exp, act);
    end
endtask

// failures that carry no value to compare
task automatic note_failure(string name, string what);
    err_cnt++;
    $display("%s: %s", name, what);
endtask

task automatic start_test();
    test_err_base = err_cnt;
endtask

task automatic end_test(string name);
    if (err_cnt == test_err_base)
    begin
        pass_tests++;
        $display("test %s: ok", name);
    end
    else
    begin
        fail_tests++;
        $display("test %s: %0d errors", name, err_cnt - test_err_base);
    end
endtask

`endif

/* sim/tb_axi_mem_slave.sv */
// testbench for the AXI memory slave; replays sim/slave_trace.txt against a reference memory model
module tb_axi_mem_slave;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 1024;
    localparam string TRACE = "sim/slave_trace.txt";

    logic                   ACLK = 1'b0;
    logic                   ARESETn;
    logic                   aw_valid;
    axi_bus_pkg::addr_req_t aw;
    logic                   aw_ready;
    logic                   w_valid;
    axi_bus_pkg::w_beat_t   w;
    logic                   w_ready;
    logic                   b_valid;
    axi_bus_pkg::b_beat_t   b;
    logic                   b_ready;
    logic                   ar_valid;
    axi_bus_pkg::addr_req_t ar;
    logic                   ar_ready;
    logic                   r_valid;
    axi_bus_pkg::r_beat_t   r;
    logic                   r_ready;

    logic [15:0]        lfsr_q = 16'd18;
    int                 cycles = 0;
    int                 cycle_limit = 1000000;   // replaced once the trace is counted
    axi_bus_pkg::data_t ref_mem [int];            // byte-exact model of the slave memory
    axi_bus_pkg::data_t wdata [16];
    int                 rd_id [4];
    int                 rd_start [4];
    int                 rd_len [4];
    axi_bus_pkg::data_t rd_exp [4][16];

    `include "tb_checks.svh"

    always #5 ACLK = ~ACLK;

    axi_mem_slave #(.MEM_WORDS(MEM_WORDS)) i_axi_mem_slave (
        .ACLK, .ARESETn,
        .aw_valid, .aw, .aw_ready,
        .w_valid, .w, .w_ready,
        .b_valid, .b, .b_ready,
        .ar_valid, .ar, .ar_ready,
        .r_valid, .r, .r_ready
    );

    always @(posedge ACLK)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic axi_bus_pkg::data_t ref_word(int idx);
        if (ref_mem.exists(idx))
            return ref_mem[idx];
        return 'x;
    endfunction

    // ------------------------------------------------------------------------
    // master side channel tasks
    // ------------------------------------------------------------------------
    task automatic send_aw(int id, int start, int len);
        logic hit;
        aw.id    = axi_bus_pkg::id_t'(id);
        aw.addr  = axi_bus_pkg::addr_t'(start * 4);
        aw.len   = axi_bus_pkg::len_t'(len);
        aw_valid = 1'b1;
        do
        begin
            @(negedge ACLK);
            hit = aw_ready;
            @(posedge ACLK);
            #1;
        end
        while (!hit);
        aw_valid = 1'b0;
    endtask

    task automatic send_w(int id, int start, int len, axi_bus_pkg::strb_t strb);
        logic hit;
        int   idx;
        for (int k = 0; k <= len; k++)
        begin
            idx = (start + k) % MEM_WORDS;
            if (!ref_mem.exists(idx))
                ref_mem[idx] = 'x;
            for (int lane = 0; lane < 4; lane++)
                if (strb[lane])
                    ref_mem[idx][lane*8 +: 8] = wdata[k][lane*8 +: 8];
            w.id   = axi_bus_pkg::id_t'(id);
            w.data = wdata[k];
            w.strb = strb;
            w.last = (k == len);
            do
            begin
                w_valid = lfsr_bit() | lfsr_bit();   // about one gap in four
                @(negedge ACLK);
                hit = w_valid && w_ready;
                @(posedge ACLK);
                #1;
            end
            while (!hit);
        end
        w_valid = 1'b0;
    endtask

    // responses are expected in the order given
    task automatic recv_b(string name, int first, int second, int count);
        logic hit;
        for (int i = 0; i < count; i++)
        begin
            do
            begin
                b_ready = lfsr_bit() | lfsr_bit();
                @(negedge ACLK);
                hit = b_valid && b_ready;
                if (hit)
                begin
                    check_id(name, axi_bus_pkg::id_t'(i == 0 ? first : second), b.id);
                    check_resp(name, axi_bus_pkg::RESP_OKAY, b.resp);
                end
                @(posedge ACLK);
                #1;
            end
            while (!hit);
        end
        b_ready = 1'b0;
        @(negedge ACLK);
        if (b_valid)
            note_failure(name, "an extra write response appeared");
        @(posedge ACLK);
        #1;
    endtask

    // all ARs go out with r_ready low and then beats follow round robin
    task automatic run_reads(string name, int count);
        logic hit;
        int   remaining [4];
        int   sent [4];
        int   slot [4];
        int   total;
        int   got;
        int   last;
        int   exp_id;
        int   g;
        total = 0;
        for (int i = 0; i < 4; i++)
        begin
            remaining[i] = 0;
            sent[i]      = 0;
        end
        r_ready = 1'b0;
        for (int i = 0; i < count; i++)
        begin
            ar.id    = axi_bus_pkg::id_t'(rd_id[i]);
            ar.addr  = axi_bus_pkg::addr_t'(rd_start[i] * 4);
            ar.len   = axi_bus_pkg::len_t'(rd_len[i]);
            ar_valid = 1'b1;
            do
            begin
                @(negedge ACLK);
                hit = ar_ready;
                @(posedge ACLK);
                #1;
            end
            while (!hit);
            ar_valid = 1'b0;
            slot[rd_id[i]]      = i;
            remaining[rd_id[i]] = rd_len[i] + 1;
            total += rd_len[i] + 1;
        end
        got  = 0;
        last = 0;
        while (got < total)
        begin
            r_ready = lfsr_bit() | lfsr_bit();
            @(negedge ACLK);
            if (r_valid && r_ready)
            begin
                exp_id = -1;
                if (got == 0)
                    exp_id = rd_id[0];   // issued before the other ARs arrive
                else
                    for (int s = 1; s <= 4; s++)
                        if (exp_id < 0 && remaining[(last + s) % 4] > 0)
                            exp_id = (last + s) % 4;
                g = slot[exp_id];
                check_id(name, axi_bus_pkg::id_t'(exp_id), r.id);
                check_data(name, ref_word((rd_start[g] + sent[exp_id]) % MEM_WORDS), r.data);
                check_data(name, rd_exp[g][sent[exp_id]], r.data);
                check_last(name, sent[exp_id] == rd_len[g], r.last);
                check_resp(name, axi_bus_pkg::RESP_OKAY, r.resp);
                sent[exp_id]++;
                remaining[exp_id]--;
                last = exp_id;
                got++;
            end
            @(posedge ACLK);
            #1;
        end
        r_ready = 1'b0;
        @(negedge ACLK);
        if (r_valid)
            note_failure(name, "an extra read beat appeared");
        @(posedge ACLK);
        #1;
    endtask

    // ------------------------------------------------------------------------
    // trace replay
    // ------------------------------------------------------------------------
    initial
    begin
        int                 fd;
        int                 n;
        int                 beats;
        int                 a;
        int                 c;
        int                 st;
        int                 ln;
        int                 gcount;
        string              kind;
        string              nm;
        string              line;
        axi_bus_pkg::strb_t sb;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b0;
        ARESETn  = 1'b0;
        fd = $fopen(TRACE, "r");
        if (fd == 0)
            note_failure(TRACE, "the trace file could not be opened");
        else
        begin
            beats = 0;
            while ($fgets(line, fd) > 0)
            begin
                kind = "";
                n = $sscanf(line, "%s %s %d %d %d", kind, nm, a, st, c);
                if (kind == "W" || kind == "R")
                    beats += c + 1;
                else if (kind == "O")
                    beats += 2;
            end
            $fclose(fd);
            cycle_limit = 40 * beats + 200;
            fd = $fopen(TRACE, "r");
        end
        repeat (4) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        while (fd != 0 && $fscanf(fd, "%s", kind) == 1)
        begin
            if (kind == "W")
            begin
                n = $fscanf(fd, "%s %d %d %d %h", nm, a, st, ln, sb);
                for (int k = 0; k <= ln; k++)
                    n = $fscanf(fd, "%h", wdata[k]);
                start_test();
                send_aw(a, st, ln);
                send_w(a, st, ln, sb);
                recv_b(nm, a, a, 1);
                end_test(nm);
            end
            else if (kind == "G")
            begin
                n = $fscanf(fd, "%s %d", nm, gcount);
                for (int i = 0; i < gcount; i++)
                begin
                    n = $fscanf(fd, "%s %s %d %d %d", kind, nm, rd_id[i], rd_start[i], rd_len[i]);
                    for (int k = 0; k <= rd_len[i]; k++)
                        n = $fscanf(fd, "%h", rd_exp[i][k]);
                end
                start_test();
                run_reads(nm, gcount);
                end_test(nm);
            end
            else if (kind == "O")
            begin
                n = $fscanf(fd, "%s %d %d %d %h %h", nm, a, c, st, wdata[0], wdata[1]);
                start_test();
                send_aw(a, st, 0);
                send_w(a, st, 0, 4'hf);
                aw.id = axi_bus_pkg::id_t'(a);   // look at aw_ready without offering AW
                repeat (3)
                begin
                    @(negedge ACLK);
                    if (aw_ready)
                        note_failure(nm, "aw_ready was high while the ID still owed a response");
                    @(posedge ACLK);
                    #1;
                end
                wdata[0] = wdata[1];
                send_aw(c, st + 1, 0);
                send_w(c, st + 1, 0, 4'hf);
                recv_b(nm, a, c, 2);
                aw.id = axi_bus_pkg::id_t'(a);
                @(negedge ACLK);
                if (!aw_ready)
                    note_failure(nm, "aw_ready stayed low after the response went out");
                @(posedge ACLK);
                #1;
                end_test(nm);
            end
            else
                n = $fgets(line, fd);   // comment line
        end
        if (fd != 0)
            $fclose(fd);
        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 pass_tests, fail_tests, chk_cnt, err_cnt);
        if (err_cnt == 0 && pass_tests > 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* sim/slave_trace.txt */
# W name id start_word len_minus_one strb, then one hex data word per beat
# G name count, then count lines of R name id start_word len_minus_one expected hex words
# O name id_a id_b start_word data_a data_b, one-beat writes with a second AW held off on id_a
W full_id0 0 16 3 f 11110000 11110001 11110002 11110003
G read_id0 1
R read_id0 0 16 3 11110000 11110001 11110002 11110003
W full_id1 1 32 7 f a1000000 a1000001 a1000002 a1000003
a1000004 a1000005 a1000006 a1000007
G read_id1 1
R read_id1 1 32 7 a1000000 a1000001 a1000002 a1000003
a1000004 a1000005 a1000006 a1000007
W strobe_lo 2 16 1 3 0000beef 0000cafe
W strobe_hi 3 17 1 c 55aa0000 66bb0000
G read_strobe 1
R read_strobe 2 16 2 1111beef 55aacafe 66bb0002
W wrap_id3 3 1022 3 f 30000000 30000001 30000002 30000003
G read_wrap 1
R read_wrap 0 1022 3 30000000 30000001 30000002 30000003
W fill_id2 2 64 15 f 20000000 20000001 20000002 20000003 20000004 20000005 20000006
20000007 20000008 20000009 2000000a 2000000b 2000000c 2000000d 2000000e 2000000f
G all_ids 4
R all_ids 0 64 3 20000000 20000001 20000002 20000003
R all_ids 1 32 1 a1000000 a1000001
R all_ids 2 68 4 20000004 20000005 20000006 20000007 20000008
R all_ids 3 16 0 1111beef
O overlap 1 2 200 abcd0001 abcd0002
G read_overlap 1
R read_overlap 1 200 1 abcd0001 abcd0002

/* sources.f */
+incdir+sim
rtl/axi_bus_pkg.sv
rtl/mem_slave_pkg.sv
rtl/word_ram.sv
rtl/rr_id_arbiter.sv
rtl/write_tracker.sv
rtl/read_tracker.sv
rtl/axi_mem_slave.sv
sim/tb_axi_mem_slave.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_axi_mem_slave -o sim_tb \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Regression passed" sim.log && exit 0 || exit 1
